// ==== radio_capture.f ====
rtl/capture_pkg.sv
rtl/mcb_pkg.sv
rtl/mem_port_if.sv
rtl/pattern_gen.sv
rtl/sample_front.sv
rtl/block_buffer.sv
rtl/capture_scheduler.sv
rtl/readout_engine.sv
rtl/mcb_arbiter.sv
rtl/radio_capture.sv
test/capture_checker.sv
test/radio_capture_tb.sv

// ==== rtl/block_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module block_buffer (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  clear_i,
   input  logic                  push_i,
   input  capture_pkg::ax_word_t data_i,
   input  logic                  pop_i,
   output capture_pkg::ax_word_t head_o,
   output logic                  empty_o,
   output logic                  full_o
);
   import capture_pkg::*;

   ax_word_t mem_q [BUF_DEPTH];
   buf_ptr_t wr_ptr_q;
   buf_ptr_t rd_ptr_q;

   // Same index, wrap bits tell empty from full
   assign empty_o = (wr_ptr_q == rd_ptr_q);
   assign full_o  = (wr_ptr_q[BUF_ABITS] != rd_ptr_q[BUF_ABITS]) &&
                    (wr_ptr_q[BUF_ABITS-1:0] == rd_ptr_q[BUF_ABITS-1:0]);
   assign head_o  = mem_q[rd_ptr_q[BUF_ABITS-1:0]];

   // Storage
   always_ff @(posedge clk_i) begin
      if (push_i && !full_o) begin
         mem_q[wr_ptr_q[BUF_ABITS-1:0]] <= data_i;
      end
   end

   // Pointers, clear wins
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push_i && !full_o) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i && !empty_o) rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/capture_pkg.sv ====
`default_nettype none

package capture_pkg;

   // --------------------
   // Antenna bank
   // --------------------
   localparam int AX_NUM = 24;
   // One sample of every antenna
   typedef logic [AX_NUM-1:0] ax_word_t;

   // --------------------
   // Sampling
   // --------------------
   // Clock cycles per sample
   localparam int SAMPLE_DIV = 6;
   // Sample phase select, also the phase counter
   typedef logic [2:0] delay_t;

   // Test pattern, maximal length taps 24/23/22/17
   localparam ax_word_t PATTERN_SEED = 24'h5A3C91;
   localparam ax_word_t PATTERN_TAPS = 24'hE10000;

   // --------------------
   // Block buffer and capture FSM
   // --------------------
   localparam int BUF_DEPTH = 16;
   localparam int BUF_ABITS = $clog2(BUF_DEPTH);
   // Index plus wrap bit
   typedef logic [BUF_ABITS:0] buf_ptr_t;

   typedef enum logic [2:0] {IDLE, FILL, DRAIN_WAIT, DONE} capture_state_t;

endpackage

`default_nettype wire

// ==== rtl/capture_scheduler.sv ====
`timescale 1ns/10ps
`default_nettype none

module capture_scheduler (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  logic                        start_i,
   input  logic                        strobe_i,
   input  capture_pkg::ax_word_t       sample_i,
   mem_port_if.requester               wr_port,
   output capture_pkg::capture_state_t state_o,
   output mcb_pkg::capture_count_t     capture_count_o,
   output logic                        overflow_o
);
   import capture_pkg::*;
   import mcb_pkg::*;

   capture_state_t state_q;
   capture_count_t push_cnt_q;
   capture_count_t wr_cnt_q;
   logic           overflow_q;
   logic           start_ok;
   logic           push;
   logic           pop;
   ax_word_t       head;
   logic           buf_empty;
   logic           buf_full;

   // --------------------
   // Buffer control
   // --------------------
   assign start_ok = start_i && ((state_q == IDLE) || (state_q == DONE));
   // Full at a strobe means the sample is lost
   assign push     = (state_q == FILL) && strobe_i && !buf_full;
   assign pop      = wr_port.req && wr_port.gnt;

   block_buffer i_buffer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .clear_i (start_ok),
      .push_i  (push),
      .data_i  (sample_i),
      .pop_i   (pop),
      .head_o  (head),
      .empty_o (buf_empty),
      .full_o  (buf_full)
   );

   // --------------------
   // Write requests
   // --------------------
   // Head word and address stay put until granted
   assign wr_port.req  = !buf_empty;
   assign wr_port.wr   = 1'b1;
   assign wr_port.adr  = wr_cnt_q[MEM_ABITS-1:0];
   assign wr_port.wdat = {{(MEM_DBITS-AX_NUM){1'b0}}, head};

   // --------------------
   // FSM
   // --------------------
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= IDLE;
         push_cnt_q <= '0;
         wr_cnt_q   <= '0;
         overflow_q <= 1'b0;
      end else begin
         // Count of granted writes, also the next address
         if (pop) wr_cnt_q <= wr_cnt_q + 1'b1;

         case (state_q)
            IDLE, DONE: begin
               if (start_i) begin
                  state_q    <= FILL;
                  push_cnt_q <= '0;
                  wr_cnt_q   <= '0;
                  overflow_q <= 1'b0;
               end
            end
            FILL: begin
               if (strobe_i && buf_full) overflow_q <= 1'b1;
               if (push) begin
                  push_cnt_q <= push_cnt_q + 1'b1;
                  // Last sample in, only draining left
                  if (push_cnt_q == capture_count_t'(CAPTURE_LEN-1)) state_q <= DRAIN_WAIT;
               end
            end
            DRAIN_WAIT: begin
               if (pop && (wr_cnt_q == capture_count_t'(CAPTURE_LEN-1))) state_q <= DONE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign state_o         = state_q;
   assign capture_count_o = wr_cnt_q;
   assign overflow_o      = overflow_q;

endmodule

`default_nettype wire

// ==== rtl/mcb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcb_arbiter (
   input  logic               clk_i,
   input  logic               rst_n_i,
   mem_port_if.arbiter        wr_port,
   mem_port_if.arbiter        rd_port,
   output logic               mcb_ce_o,
   output logic               mcb_wr_o,
   input  logic               mcb_rdy_i,
   output mcb_pkg::mem_addr_t mcb_adr_o,
   output mcb_pkg::mem_word_t mcb_dat_o,
   input  mcb_pkg::mem_word_t mcb_dat_i,
   input  logic               mcb_rvalid_i
);

   logic hold_q;
   logic hold_rd_q;
   logic rd_out_q;
   logic rd_ok;
   logic sel_wr;
   logic sel_rd;

   // --------------------
   // Selection
   // --------------------
   // Reader waits while its previous read is in flight
   assign rd_ok  = rd_port.req && !rd_out_q;
   // A stalled transfer keeps its owner until rdy
   assign sel_wr = hold_q ? !hold_rd_q : wr_port.req;
   assign sel_rd = hold_q ? hold_rd_q : (!wr_port.req && rd_ok);

   assign mcb_ce_o  = sel_wr || sel_rd;
   assign mcb_wr_o  = sel_wr ? wr_port.wr   : rd_port.wr;
   assign mcb_adr_o = sel_wr ? wr_port.adr  : rd_port.adr;
   assign mcb_dat_o = sel_wr ? wr_port.wdat : rd_port.wdat;

   assign wr_port.gnt = sel_wr && mcb_rdy_i;
   assign rd_port.gnt = sel_rd && mcb_rdy_i;

   // Read data only ever belongs to the reader
   assign rd_port.rdat   = mcb_dat_i;
   assign rd_port.rvalid = mcb_rvalid_i && rd_out_q;
   assign wr_port.rdat   = '0;
   assign wr_port.rvalid = 1'b0;

   // --------------------
   // Ownership and read tracking
   // --------------------
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         hold_q    <= 1'b0;
         hold_rd_q <= 1'b0;
         rd_out_q  <= 1'b0;
      end else begin
         hold_q    <= mcb_ce_o && !mcb_rdy_i;
         hold_rd_q <= sel_rd;
         if (mcb_rvalid_i) rd_out_q <= 1'b0;
         if (rd_port.gnt) rd_out_q <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/mcb_pkg.sv ====
`default_nettype none

package mcb_pkg;

   // --------------------
   // External memory port
   // --------------------
   localparam int MEM_ABITS = 6;
   localparam int MEM_DBITS = 32;

   typedef logic [MEM_ABITS-1:0] mem_addr_t;
   typedef logic [MEM_DBITS-1:0] mem_word_t;

   // One capture fills the whole address space
   localparam int CAPTURE_LEN = 1 << MEM_ABITS;
   // Needs one extra bit to reach CAPTURE_LEN itself
   typedef logic [MEM_ABITS:0] capture_count_t;

endpackage

`default_nettype wire

// ==== rtl/mem_port_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if;
   import mcb_pkg::*;

   // Request side, held until gnt
   logic      req;
   logic      wr;
   mem_addr_t adr;
   mem_word_t wdat;

   // Grant and read return
   logic      gnt;
   mem_word_t rdat;
   logic      rvalid;

   modport requester (
      output req, wr, adr, wdat,
      input  gnt, rdat, rvalid
   );

   modport arbiter (
      input  req, wr, adr, wdat,
      output gnt, rdat, rvalid
   );

endinterface

`default_nettype wire

// ==== rtl/pattern_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module pattern_gen (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  step_i,
   output capture_pkg::ax_word_t pattern_o
);
   import capture_pkg::*;

   ax_word_t lfsr_q;
   logic     feedback;

   // Parity of the tapped bits
   assign feedback = ^(lfsr_q & PATTERN_TAPS);

   // Shift left, feedback enters at bit 0
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         lfsr_q <= PATTERN_SEED;
      end else if (step_i) begin
         lfsr_q <= {lfsr_q[AX_NUM-2:0], feedback};
      end
   end

   assign pattern_o = lfsr_q;

endmodule

`default_nettype wire

// ==== rtl/radio_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module radio_capture (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   // Antenna side
   input  capture_pkg::ax_word_t   ax_data_i,
   input  capture_pkg::delay_t     aq_delay_i,
   input  logic                    aq_debug_i,
   input  logic                    aq_start_i,
   output capture_pkg::ax_word_t   ax_data_o,
   // External memory
   output logic                    mcb_ce_o,
   output logic                    mcb_wr_o,
   input  logic                    mcb_rdy_i,
   output mcb_pkg::mem_addr_t      mcb_adr_o,
   output mcb_pkg::mem_word_t      mcb_dat_o,
   input  mcb_pkg::mem_word_t      mcb_dat_i,
   input  logic                    mcb_rvalid_i,
   // Host readout
   input  logic                    rd_req_i,
   output mcb_pkg::mem_word_t      rd_data_o,
   output logic                    rd_valid_o,
   output logic                    rd_busy_o,
   // Status
   output logic [2:0]              tart_state_o,
   output mcb_pkg::capture_count_t capture_count_o,
   output logic                    overflow_o
);

   logic strobe;

   mem_port_if wr_port ();
   mem_port_if rd_port ();

   // Sampler, its sample word is also ax_data_o
   sample_front i_front (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ax_data_i  (ax_data_i),
      .aq_delay_i (aq_delay_i),
      .aq_debug_i (aq_debug_i),
      .sample_o   (ax_data_o),
      .strobe_o   (strobe)
   );

   capture_scheduler i_sched (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .start_i         (aq_start_i),
      .strobe_i        (strobe),
      .sample_i        (ax_data_o),
      .wr_port         (wr_port.requester),
      .state_o         (tart_state_o),
      .capture_count_o (capture_count_o),
      .overflow_o      (overflow_o)
   );

   // Start also rewinds the host read pointer
   readout_engine i_readout (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .restart_i  (aq_start_i),
      .rd_req_i   (rd_req_i),
      .rd_port    (rd_port.requester),
      .rd_data_o  (rd_data_o),
      .rd_valid_o (rd_valid_o),
      .rd_busy_o  (rd_busy_o)
   );

   mcb_arbiter i_arb (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .wr_port      (wr_port.arbiter),
      .rd_port      (rd_port.arbiter),
      .mcb_ce_o     (mcb_ce_o),
      .mcb_wr_o     (mcb_wr_o),
      .mcb_rdy_i    (mcb_rdy_i),
      .mcb_adr_o    (mcb_adr_o),
      .mcb_dat_o    (mcb_dat_o),
      .mcb_dat_i    (mcb_dat_i),
      .mcb_rvalid_i (mcb_rvalid_i)
   );

endmodule

`default_nettype wire

// ==== rtl/readout_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module readout_engine (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               restart_i,
   input  logic               rd_req_i,
   mem_port_if.requester      rd_port,
   output mcb_pkg::mem_word_t rd_data_o,
   output logic               rd_valid_o,
   output logic               rd_busy_o
);
   import mcb_pkg::*;

   mem_addr_t ptr_q;
   logic      busy_q;
   logic      pend_q;
   logic      valid_q;
   mem_word_t data_q;
   logic      accept;
   logic      issued;

   // New request only when nothing in flight
   assign accept = rd_req_i && !busy_q;
   assign issued = pend_q && rd_port.gnt;

   // Read request held until granted
   assign rd_port.req  = pend_q;
   assign rd_port.wr   = 1'b0;
   assign rd_port.adr  = ptr_q;
   assign rd_port.wdat = '0;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ptr_q   <= '0;
         busy_q  <= 1'b0;
         pend_q  <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= rd_port.rvalid && busy_q;
         if (accept) begin
            busy_q <= 1'b1;
            pend_q <= 1'b1;
         end
         if (issued) pend_q <= 1'b0;
         // Busy drops together with rd_valid_o
         if (rd_port.rvalid && busy_q) busy_q <= 1'b0;
         // Step past the word once its request is done
         if (restart_i) begin
            ptr_q <= '0;
         end else if (issued) begin
            ptr_q <= (ptr_q == mem_addr_t'(CAPTURE_LEN-1)) ? '0 : ptr_q + 1'b1;
         end
      end
   end

   // Returned word
   always_ff @(posedge clk_i) begin
      if (rd_port.rvalid) data_q <= rd_port.rdat;
   end

   assign rd_data_o  = data_q;
   assign rd_valid_o = valid_q;
   assign rd_busy_o  = busy_q;

endmodule

`default_nettype wire

// ==== rtl/sample_front.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_front (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  capture_pkg::ax_word_t ax_data_i,
   input  capture_pkg::delay_t   aq_delay_i,
   input  logic                  aq_debug_i,
   output capture_pkg::ax_word_t sample_o,
   output logic                  strobe_o
);
   import capture_pkg::*;

   delay_t   phase_q;
   delay_t   phase_sel;
   logic     take;
   ax_word_t ax_reg_q;
   ax_word_t pattern;
   ax_word_t sample_q;
   logic     strobe_q;

   // --------------------
   // Strobe phase
   // --------------------
   // Out of range phases clamp to the last slot
   assign phase_sel = (aq_delay_i > delay_t'(SAMPLE_DIV-1)) ? delay_t'(SAMPLE_DIV-1) : aq_delay_i;
   assign take      = (phase_q == phase_sel);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         phase_q <= '0;
      end else if (phase_q == delay_t'(SAMPLE_DIV-1)) begin
         phase_q <= '0;
      end else begin
         phase_q <= phase_q + 1'b1;
      end
   end

   // Fake antenna source, one step per strobe
   pattern_gen i_pattern (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .step_i    (take),
      .pattern_o (pattern)
   );

   // --------------------
   // Capture
   // --------------------
   // Input register on every clock
   always_ff @(posedge clk_i) begin
      ax_reg_q <= ax_data_i;
      if (take) begin
         sample_q <= aq_debug_i ? pattern : ax_reg_q;
      end
   end

   // Strobe out lines up with the fresh sample
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         strobe_q <= 1'b0;
      end else begin
         strobe_q <= take;
      end
   end

   assign sample_o = sample_q;
   assign strobe_o = strobe_q;

endmodule

`default_nettype wire

// ==== test/capture_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module capture_checker (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   // DUT inputs
   input  capture_pkg::ax_word_t   ax_in_i,
   input  capture_pkg::delay_t     delay_i,
   input  logic                    debug_i,
   input  logic                    start_i,
   // DUT outputs
   input  capture_pkg::ax_word_t   ax_out_i,
   input  logic [2:0]              state_i,
   input  mcb_pkg::capture_count_t count_i,
   input  logic                    overflow_i,
   input  mcb_pkg::mem_word_t      rd_data_i,
   input  logic                    rd_valid_i,
   input  logic                    rd_busy_i,
   // Memory bus
   input  logic                    mcb_ce_i,
   input  logic                    mcb_wr_i,
   input  logic                    mcb_rdy_i,
   input  mcb_pkg::mem_addr_t      mcb_adr_i,
   input  mcb_pkg::mem_word_t      mcb_wdat_i,
   output int                      errors_o
);
   import capture_pkg::*;
   import mcb_pkg::*;

   int             err_cnt = 0;
   // Sampler model
   delay_t         phase;
   delay_t         sel;
   ax_word_t       ax_reg;
   ax_word_t       pattern;
   ax_word_t       last_sample;
   logic           have_sample;
   logic           strobe_pend;
   // Capture model, the queue mirrors the block buffer
   capture_state_t state;
   ax_word_t       buf_q [$];
   logic           buf_full;
   ax_word_t       head;
   mem_word_t      exp_word;
   int             pushed;
   int             written;
   logic           ovf;
   mem_word_t      exp_mem [CAPTURE_LEN];
   // Readout model
   int             rd_ptr;
   int             rd_addr_q [$];
   int             addr;
   logic           busy_prev;

   assign errors_o = err_cnt;

   // Shift left, parity of tapped bits enters at bit 0
   function automatic ax_word_t lfsr_next(input ax_word_t w);
      return {w[AX_NUM-2:0], ^(w & PATTERN_TAPS)};
   endfunction

   task automatic flag_error(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      err_cnt++;
   endtask

   // All model state moves on the rising edge, DUT values seen before the edge
   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         phase       = '0;
         pattern     = PATTERN_SEED;
         have_sample = 1'b0;
         strobe_pend = 1'b0;
         state       = IDLE;
         buf_q.delete();
         pushed      = 0;
         written     = 0;
         ovf         = 1'b0;
         rd_ptr      = 0;
         rd_addr_q.delete();
         busy_prev   = 1'b0;
      end else begin
         // --------------------
         // Status outputs
         // --------------------
         if (state_i !== state)
            flag_error($sformatf("state %0d, expected %0d", state_i, state));
         if (count_i !== capture_count_t'(written))
            flag_error($sformatf("capture count %0d, expected %0d", count_i, written));
         if (overflow_i !== ovf)
            flag_error($sformatf("overflow %b, expected %b", overflow_i, ovf));
         if (have_sample && (ax_out_i !== last_sample))
            flag_error($sformatf("ax_data_o %h, expected %h", ax_out_i, last_sample));
         // Nothing may reach memory before the first capture
         if ((state == IDLE) && (rd_busy_i === 1'b0) && (mcb_ce_i !== 1'b0))
            flag_error("memory enable active while idle");

         // Buffer level before this edge decides a drop
         buf_full = (buf_q.size() == BUF_DEPTH);

         // --------------------
         // Memory writes
         // --------------------
         if (mcb_ce_i && mcb_wr_i && mcb_rdy_i) begin
            if (buf_q.size() == 0) begin
               flag_error("memory write with no sample in the buffer");
            end else begin
               head     = buf_q.pop_front();
               exp_word = {8'h00, head};
               if (mcb_adr_i !== mem_addr_t'(written))
                  flag_error($sformatf("write address %0d, expected %0d", mcb_adr_i, written));
               if (mcb_wdat_i !== exp_word)
                  flag_error($sformatf("write data %h, expected %h", mcb_wdat_i, exp_word));
               exp_mem[written % CAPTURE_LEN] = exp_word;
               written++;
               if ((written == CAPTURE_LEN) && (state == DRAIN_WAIT)) state = DONE;
            end
         end

         // --------------------
         // Host readout
         // --------------------
         if (mcb_ce_i && !mcb_wr_i && mcb_rdy_i) begin
            if (mcb_adr_i !== mem_addr_t'(rd_ptr))
               flag_error($sformatf("read address %0d, expected %0d", mcb_adr_i, rd_ptr));
            rd_addr_q.push_back(rd_ptr);
            rd_ptr = (rd_ptr + 1) % CAPTURE_LEN;
         end
         if (rd_valid_i) begin
            if (rd_addr_q.size() == 0) begin
               flag_error("read data returned with no read issued");
            end else begin
               addr = rd_addr_q.pop_front();
               if (rd_data_i !== exp_mem[addr])
                  flag_error($sformatf("read word %0d is %h, expected %h",
                                       addr, rd_data_i, exp_mem[addr]));
            end
            if (rd_busy_i || !busy_prev) flag_error("rd_busy_o did not fall with rd_valid_o");
         end

         // Sample strobe lands one cycle after the take
         if (strobe_pend && (state == FILL)) begin
            if (buf_full) begin
               ovf = 1'b1;
            end else begin
               buf_q.push_back(last_sample);
               pushed++;
               if (pushed == CAPTURE_LEN) state = DRAIN_WAIT;
            end
         end
         strobe_pend = 1'b0;

         // Start rewinds the read pointer in any state
         if (start_i) begin
            rd_ptr = 0;
            if ((state == IDLE) || (state == DONE)) begin
               state   = FILL;
               buf_q.delete();
               pushed  = 0;
               written = 0;
               ovf     = 1'b0;
            end
         end

         // --------------------
         // Sampler
         // --------------------
         // Phases 6 and 7 behave as 5
         sel = (delay_i >= 3'd6) ? 3'd5 : delay_i;
         if (phase == sel) begin
            last_sample = debug_i ? pattern : ax_reg;
            pattern     = lfsr_next(pattern);
            have_sample = 1'b1;
            strobe_pend = 1'b1;
         end
         phase     = (phase == delay_t'(SAMPLE_DIV-1)) ? '0 : phase + 3'd1;
         busy_prev = rd_busy_i;
      end
      // Antenna register runs on every clock
      ax_reg = ax_in_i;
   end

endmodule

`default_nettype wire

// ==== test/radio_capture_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module radio_capture_tb;
   import capture_pkg::*;
   import mcb_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_TESTS  = 6;
   // Memory ready behaviour
   localparam int RDY_HIGH   = 0;
   localparam int RDY_RANDOM = 1;
   localparam int RDY_LOW    = 2;

   logic           clk_i;
   logic           rst_n_i;
   ax_word_t       ax_data_i;
   delay_t         aq_delay_i;
   logic           aq_debug_i;
   logic           aq_start_i;
   ax_word_t       ax_data_o;
   logic           mcb_ce_o;
   logic           mcb_wr_o;
   logic           mcb_rdy_i;
   mem_addr_t      mcb_adr_o;
   mem_word_t      mcb_dat_o;
   mem_word_t      mcb_dat_i;
   logic           mcb_rvalid_i;
   logic           rd_req_i;
   mem_word_t      rd_data_o;
   logic           rd_valid_o;
   logic           rd_busy_o;
   logic [2:0]     tart_state_o;
   capture_count_t capture_count_o;
   logic           overflow_o;

   // Memory model and bookkeeping
   mem_word_t      mem [CAPTURE_LEN];
   mem_word_t      ret_word;
   int             ret_wait;
   int             rdy_mode;
   int             seed;
   int             reads;
   int             chk_errors;
   int             errs_before;
   int             passed;
   int             failed;

   radio_capture i_dut (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .ax_data_i       (ax_data_i),
      .aq_delay_i      (aq_delay_i),
      .aq_debug_i      (aq_debug_i),
      .aq_start_i      (aq_start_i),
      .ax_data_o       (ax_data_o),
      .mcb_ce_o        (mcb_ce_o),
      .mcb_wr_o        (mcb_wr_o),
      .mcb_rdy_i       (mcb_rdy_i),
      .mcb_adr_o       (mcb_adr_o),
      .mcb_dat_o       (mcb_dat_o),
      .mcb_dat_i       (mcb_dat_i),
      .mcb_rvalid_i    (mcb_rvalid_i),
      .rd_req_i        (rd_req_i),
      .rd_data_o       (rd_data_o),
      .rd_valid_o      (rd_valid_o),
      .rd_busy_o       (rd_busy_o),
      .tart_state_o    (tart_state_o),
      .capture_count_o (capture_count_o),
      .overflow_o      (overflow_o)
   );

   capture_checker i_chk (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ax_in_i    (ax_data_i),
      .delay_i    (aq_delay_i),
      .debug_i    (aq_debug_i),
      .start_i    (aq_start_i),
      .ax_out_i   (ax_data_o),
      .state_i    (tart_state_o),
      .count_i    (capture_count_o),
      .overflow_i (overflow_o),
      .rd_data_i  (rd_data_o),
      .rd_valid_i (rd_valid_o),
      .rd_busy_i  (rd_busy_o),
      .mcb_ce_i   (mcb_ce_o),
      .mcb_wr_i   (mcb_wr_o),
      .mcb_rdy_i  (mcb_rdy_i),
      .mcb_adr_i  (mcb_adr_o),
      .mcb_wdat_i (mcb_dat_o),
      .errors_o   (chk_errors)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
   end

   // --------------------
   // One clock of stimulus and memory
   // --------------------
   task automatic run_cycle();
      @(posedge clk_i);
      // Transfer completes at this edge
      if (mcb_ce_o && mcb_rdy_i) begin
         if (mcb_wr_o) begin
            mem[mcb_adr_o] = mcb_dat_o;
         end else begin
            ret_word = mem[mcb_adr_o];
            ret_wait = 1 + ($unsigned($random(seed)) % 4);
         end
      end
      #1;
      aq_start_i = 1'b0;
      rd_req_i   = 1'b0;
      ax_data_i  = $random(seed);
      case (rdy_mode)
         RDY_HIGH: mcb_rdy_i = 1'b1;
         RDY_LOW:  mcb_rdy_i = 1'b0;
         default:  mcb_rdy_i = ($unsigned($random(seed)) % 4) != 0;
      endcase
      // Read return, one cycle wide, junk data otherwise
      mcb_rvalid_i = 1'b0;
      mcb_dat_i    = $random(seed);
      if (ret_wait > 0) begin
         ret_wait--;
         if (ret_wait == 0) begin
            mcb_rvalid_i = 1'b1;
            mcb_dat_i    = ret_word;
         end
      end
   endtask

   // Capture at a random phase, optionally reading behind the writer
   task automatic run_capture(input logic debug, input int mode, input int low_cycles,
                              input logic read_along);
      aq_debug_i = debug;
      aq_delay_i = delay_t'($unsigned($random(seed)) % SAMPLE_DIV);
      rdy_mode   = (low_cycles > 0) ? RDY_LOW : mode;
      reads      = 0;
      aq_start_i = 1'b1;
      run_cycle();
      repeat (low_cycles) run_cycle();
      rdy_mode = mode;
      while (tart_state_o != DONE) begin
         run_cycle();
         // Only words already written may be read
         if (read_along && !rd_busy_o && (reads < int'(capture_count_o)) &&
             (($unsigned($random(seed)) % 3) == 0)) begin
            rd_req_i = 1'b1;
            reads++;
         end
      end
   endtask

   task automatic read_words(input int n);
      repeat (n) begin
         rd_req_i = 1'b1;
         run_cycle();
         while (!rd_valid_o) run_cycle();
      end
   endtask

   task automatic finish_test(input int num, input string name);
      run_cycle();
      while (rd_busy_o) run_cycle();
      repeat (2) run_cycle();
      if (chk_errors == errs_before) begin
         passed++;
         $display("Test %0d %s: passed", num, name);
      end else begin
         failed++;
         $display("Test %0d %s: failed with %0d errors", num, name, chk_errors - errs_before);
      end
      errs_before = chk_errors;
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      seed         = 37;
      rst_n_i      = 1'b0;
      ax_data_i    = '0;
      aq_delay_i   = '0;
      aq_debug_i   = 1'b0;
      aq_start_i   = 1'b0;
      mcb_rdy_i    = 1'b0;
      mcb_dat_i    = '0;
      mcb_rvalid_i = 1'b0;
      rd_req_i     = 1'b0;
      rdy_mode     = RDY_HIGH;
      ret_word     = '0;
      ret_wait     = 0;
      reads        = 0;
      errs_before  = 0;
      passed       = 0;
      failed       = 0;
      // Fill word carries its own address
      for (int a = 0; a < CAPTURE_LEN; a++) begin
         mem[a] = 32'hFF00_0000 | a;
      end
      repeat (5) run_cycle();
      rst_n_i = 1'b1;

      run_capture(1'b0, RDY_HIGH, 0, 1'b0);
      finish_test(1, "antenna capture");
      run_capture(1'b1, RDY_HIGH, 0, 1'b0);
      finish_test(2, "test pattern capture");
      rdy_mode = RDY_RANDOM;
      read_words(CAPTURE_LEN);
      finish_test(3, "readout after capture");
      run_capture(1'b0, RDY_RANDOM, 0, 1'b1);
      finish_test(4, "readout during capture");
      run_capture(1'b0, RDY_RANDOM, 40 * SAMPLE_DIV, 1'b0);
      finish_test(5, "back-pressure overflow");
      // Move the read pointer, then restart must rewind it
      read_words(5);
      run_capture(1'b0, RDY_HIGH, 0, 1'b0);
      read_words(8);
      finish_test(6, "restart");

      $display("Tests: %0d, passed: %0d, failed: %0d, errors: %0d",
               NUM_TESTS, passed, failed, chk_errors);
      if ((failed == 0) && (chk_errors == 0)) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog sized from the capture length of every test
   initial begin
      repeat (NUM_TESTS * (CAPTURE_LEN * SAMPLE_DIV + 400)) @(posedge clk_i);
      $display("Timeout: the tests did not complete within %0d clock cycles",
               NUM_TESTS * (CAPTURE_LEN * SAMPLE_DIV + 400));
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire
